//--- logic/rvExecPkg.sv
package rvExecPkg;

    // data path and field widths
    typedef logic [63:0] xlen_t;
    typedef logic [6:0]  opcode_t;
    // {funct7[5], funct7[0], funct3}
    typedef logic [4:0]  aluFunct_t;
    typedef logic [3:0]  aluOp_t;
    typedef logic [3:0]  tag_t;

    // codes 6, 13 and 14 are decoded by aluControl
    typedef enum logic [3:0] {
        stIdle   = 4'd0,
        stDecode = 4'd1,
        stExecR  = 4'd6,
        stWrite  = 4'd7,
        stExecI  = 4'd13,
        stBranch = 4'd14
    } seqState_e;

    // alu operation numbering
    localparam aluOp_t aluAdd  = 4'd0;
    localparam aluOp_t aluAnd  = 4'd1;
    localparam aluOp_t aluOr   = 4'd2;
    localparam aluOp_t aluSub  = 4'd3;
    localparam aluOp_t aluXor  = 4'd4;
    localparam aluOp_t aluSlt  = 4'd5;
    localparam aluOp_t aluSltu = 4'd6;
    localparam aluOp_t aluSll  = 4'd7;
    localparam aluOp_t aluSrl  = 4'd8;
    localparam aluOp_t aluSra  = 4'd9;
    localparam aluOp_t aluAddw = 4'd10;
    localparam aluOp_t aluSubw = 4'd11;
    localparam aluOp_t aluSllw = 4'd12;
    localparam aluOp_t aluSrlw = 4'd13;
    localparam aluOp_t aluSraw = 4'd14;

    // major opcodes handled by the stage
    localparam opcode_t opOp      = 7'b0110011;
    localparam opcode_t opOpImm   = 7'b0010011;
    localparam opcode_t opOp32    = 7'b0111011;
    localparam opcode_t opOpImm32 = 7'b0011011;
    localparam opcode_t opBranch  = 7'b1100011;

    typedef struct packed {
        tag_t      tag;
        opcode_t   opcode;
        aluFunct_t funct;
        xlen_t     rs1Val;
        xlen_t     rs2Val;
        xlen_t     imm;
    } instr_t;

    typedef struct packed {
        tag_t  tag;
        xlen_t value;
    } result_t;

endpackage

//--- logic/instrQueue.sv
`timescale 1ns/1ps

module instrQueue #(
    parameter int queueDepth = 4
) (
    input  logic              clk,
    input  logic              arstN,
    input  logic              push,
    input  rvExecPkg::instr_t pushData,
    input  logic              pop,
    output logic              headValid,
    output rvExecPkg::instr_t head,
    output logic              instrCredit
);

    // pointer width of at least one bit
    localparam int ptrW = (queueDepth > 1) ? $clog2(queueDepth) : 1;
    localparam int cntW = $clog2(queueDepth + 1);

    rvExecPkg::instr_t mem [queueDepth];
    logic [ptrW-1:0]   wrPtr;
    logic [ptrW-1:0]   rdPtr;
    logic [cntW-1:0]   count;

    // entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    // pointers wrap at queueDepth rather than a power of two
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr       <= '0;
            rdPtr       <= '0;
            count       <= '0;
            instrCredit <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == ptrW'(queueDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == ptrW'(queueDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            // simultaneous push and pop leaves occupancy unchanged
            count       <= count + cntW'(push) - cntW'(pop);
            // one credit back per freed slot
            instrCredit <= pop;
        end
    end

    assign headValid = (count != '0);
    assign head      = mem[rdPtr];

endmodule

//--- logic/aluControl.sv
`timescale 1ns/1ps

module aluControl (
    input  rvExecPkg::opcode_t   opcode,
    input  rvExecPkg::aluFunct_t funct,
    input  rvExecPkg::seqState_e state,
    output rvExecPkg::aluOp_t    operation
);

    always_comb begin
        // anything unrecognised falls back to add
        operation = rvExecPkg::aluAdd;
        if (state == rvExecPkg::stBranch) begin
            // branch compare by subtraction
            operation = rvExecPkg::aluSub;
        end else if (state == rvExecPkg::stExecR && opcode == rvExecPkg::opOp) begin
            // register forms need funct[3] clear except for shifts
            case (funct[2:0])
                3'b000: if (funct == 5'b10000) operation = rvExecPkg::aluSub;
                3'b001: operation = rvExecPkg::aluSll;
                3'b010: if (!funct[3]) operation = rvExecPkg::aluSlt;
                3'b011: if (!funct[3]) operation = rvExecPkg::aluSltu;
                3'b100: if (!funct[3]) operation = rvExecPkg::aluXor;
                3'b101: begin
                    // arithmetic wins over logical
                    if (funct[4]) begin
                        operation = rvExecPkg::aluSra;
                    end else if (!funct[3]) begin
                        operation = rvExecPkg::aluSrl;
                    end
                end
                3'b110: if (!funct[3]) operation = rvExecPkg::aluOr;
                default: if (!funct[3]) operation = rvExecPkg::aluAnd;
            endcase
        end else if (state == rvExecPkg::stExecI && opcode == rvExecPkg::opOpImm) begin
            // immediate forms look at funct3 and bit 4 for shifts
            case (funct[2:0])
                3'b000: operation = rvExecPkg::aluAdd;
                3'b001: operation = rvExecPkg::aluSll;
                3'b010: operation = rvExecPkg::aluSlt;
                3'b011: operation = rvExecPkg::aluSltu;
                3'b100: operation = rvExecPkg::aluXor;
                3'b101: operation = funct[4] ? rvExecPkg::aluSra : rvExecPkg::aluSrl;
                3'b110: operation = rvExecPkg::aluOr;
                default: operation = rvExecPkg::aluAnd;
            endcase
        end else if (state == rvExecPkg::stExecR && opcode == rvExecPkg::opOp32) begin
            // word register forms with subw gated by state like the rest
            case (funct[2:0])
                3'b000: operation = funct[4] ? rvExecPkg::aluSubw : rvExecPkg::aluAddw;
                3'b001: operation = rvExecPkg::aluSllw;
                3'b101: operation = funct[4] ? rvExecPkg::aluSraw : rvExecPkg::aluSrlw;
                default: operation = rvExecPkg::aluAdd;
            endcase
        end else if (state == rvExecPkg::stExecI && opcode == rvExecPkg::opOpImm32) begin
            // word immediate forms
            case (funct[2:0])
                3'b000: operation = rvExecPkg::aluAddw;
                3'b001: operation = rvExecPkg::aluSllw;
                3'b101: operation = funct[4] ? rvExecPkg::aluSraw : rvExecPkg::aluSrlw;
                default: operation = rvExecPkg::aluAdd;
            endcase
        end
    end

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps

module alu (
    input  rvExecPkg::aluOp_t operation,
    input  rvExecPkg::xlen_t  a,
    input  rvExecPkg::xlen_t  b,
    output rvExecPkg::xlen_t  result
);

    logic [31:0] aWord;
    logic [31:0] bWord;
    logic [31:0] wordRes;
    logic [5:0]  shamt;
    logic [4:0]  shamtW;

    // low words and shift amounts
    assign aWord  = a[31:0];
    assign bWord  = b[31:0];
    assign shamt  = b[5:0];
    assign shamtW = b[4:0];

    // 32-bit results for the word forms
    always_comb begin
        case (operation)
            rvExecPkg::aluAddw: wordRes = aWord + bWord;
            rvExecPkg::aluSubw: wordRes = aWord - bWord;
            rvExecPkg::aluSllw: wordRes = aWord << shamtW;
            rvExecPkg::aluSrlw: wordRes = aWord >> shamtW;
            rvExecPkg::aluSraw: wordRes = $unsigned($signed(aWord) >>> shamtW);
            default:            wordRes = '0;
        endcase
    end

    always_comb begin
        case (operation)
            rvExecPkg::aluAdd:  result = a + b;
            rvExecPkg::aluAnd:  result = a & b;
            rvExecPkg::aluOr:   result = a | b;
            rvExecPkg::aluSub:  result = a - b;
            rvExecPkg::aluXor:  result = a ^ b;
            // compares give 0 or 1
            rvExecPkg::aluSlt:  result = {63'b0, $signed(a) < $signed(b)};
            rvExecPkg::aluSltu: result = {63'b0, a < b};
            rvExecPkg::aluSll:  result = a << shamt;
            rvExecPkg::aluSrl:  result = a >> shamt;
            rvExecPkg::aluSra:  result = $unsigned($signed(a) >>> shamt);
            // word forms sign-extended from bit 31
            rvExecPkg::aluAddw,
            rvExecPkg::aluSubw,
            rvExecPkg::aluSllw,
            rvExecPkg::aluSrlw,
            rvExecPkg::aluSraw: result = {{32{wordRes[31]}}, wordRes};
            default:            result = '0;
        endcase
    end

endmodule

//--- logic/execSequencer.sv
`timescale 1ns/1ps

module execSequencer #(
    parameter int resCredits = 2
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 headValid,
    input  rvExecPkg::instr_t    head,
    output logic                 pop,
    output rvExecPkg::seqState_e state,
    output rvExecPkg::opcode_t   curOpcode,
    output rvExecPkg::aluFunct_t curFunct,
    output rvExecPkg::xlen_t     operandA,
    output rvExecPkg::xlen_t     operandB,
    input  rvExecPkg::xlen_t     aluResult,
    output logic                 resValid,
    output rvExecPkg::result_t   res,
    input  logic                 resCreditReturn
);

    localparam int cntW = $clog2(resCredits + 1);

    rvExecPkg::seqState_e nextState;
    rvExecPkg::seqState_e execState;
    rvExecPkg::instr_t    cur;
    rvExecPkg::xlen_t     resultReg;
    logic [cntW-1:0]      creditCnt;
    logic                 branchTaken;

    // only issue while a downstream slot is free
    assign pop = (state == rvExecPkg::stIdle) && headValid && (creditCnt != '0);

    // execute state chosen by opcode
    always_comb begin
        case (cur.opcode)
            rvExecPkg::opOp,
            rvExecPkg::opOp32:   execState = rvExecPkg::stExecR;
            rvExecPkg::opBranch: execState = rvExecPkg::stBranch;
            // immediate forms and unknown opcodes take rs1 + imm
            default:             execState = rvExecPkg::stExecI;
        endcase
    end

    always_comb begin
        case (state)
            rvExecPkg::stIdle:   nextState = pop ? rvExecPkg::stDecode : rvExecPkg::stIdle;
            rvExecPkg::stDecode: nextState = execState;
            rvExecPkg::stExecR,
            rvExecPkg::stExecI,
            rvExecPkg::stBranch: nextState = rvExecPkg::stWrite;
            default:             nextState = rvExecPkg::stIdle;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= rvExecPkg::stIdle;
        end else begin
            state <= nextState;
        end
    end

    // beq on zero difference, bne inverts
    assign branchTaken = (aluResult == '0) ^ (cur.funct[2:0] == 3'b001);

    // instruction and result payload
    always_ff @(posedge clk) begin
        if (pop) begin
            cur <= head;
        end
        if (state == rvExecPkg::stBranch) begin
            resultReg <= {63'b0, branchTaken};
        end else if (state == rvExecPkg::stExecR || state == rvExecPkg::stExecI) begin
            resultReg <= aluResult;
        end
    end

    // credits down on send, up on return
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            creditCnt <= cntW'(resCredits);
        end else if (resValid && !resCreditReturn) begin
            creditCnt <= creditCnt - 1'b1;
        end else if (!resValid && resCreditReturn) begin
            creditCnt <= creditCnt + 1'b1;
        end
    end

    assign curOpcode = cur.opcode;
    assign curFunct  = cur.funct;
    assign operandA  = cur.rs1Val;
    // immediate only in the immediate execute state
    assign operandB  = (state == rvExecPkg::stExecI) ? cur.imm : cur.rs2Val;

    // one-cycle pulse in the write state
    assign resValid  = (state == rvExecPkg::stWrite);
    assign res.tag   = cur.tag;
    assign res.value = resultReg;

endmodule

//--- logic/execUnit.sv
`timescale 1ns/1ps

module execUnit #(
    parameter int queueDepth = 4,
    parameter int resCredits = 2
) (
    input  logic               clk,
    input  logic               arstN,
    input  logic               instrValid,
    input  rvExecPkg::instr_t  instr,
    output logic               instrCredit,
    output logic               resValid,
    output rvExecPkg::result_t res,
    input  logic               resCreditReturn
);

    logic                 headValid;
    rvExecPkg::instr_t    head;
    logic                 pop;
    rvExecPkg::seqState_e state;
    rvExecPkg::opcode_t   curOpcode;
    rvExecPkg::aluFunct_t curFunct;
    rvExecPkg::aluOp_t    operation;
    rvExecPkg::xlen_t     operandA;
    rvExecPkg::xlen_t     operandB;
    rvExecPkg::xlen_t     aluResult;

    // input side, credit-based
    instrQueue #(
        .queueDepth(queueDepth)
    ) u_queue (
        .clk        (clk),
        .arstN      (arstN),
        .push       (instrValid),
        .pushData   (instr),
        .pop        (pop),
        .headValid  (headValid),
        .head       (head),
        .instrCredit(instrCredit)
    );

    // multicycle control and output credits
    execSequencer #(
        .resCredits(resCredits)
    ) u_seq (
        .clk            (clk),
        .arstN          (arstN),
        .headValid      (headValid),
        .head           (head),
        .pop            (pop),
        .state          (state),
        .curOpcode      (curOpcode),
        .curFunct       (curFunct),
        .operandA       (operandA),
        .operandB       (operandB),
        .aluResult      (aluResult),
        .resValid       (resValid),
        .res            (res),
        .resCreditReturn(resCreditReturn)
    );

    aluControl u_aluCtrl (
        .opcode   (curOpcode),
        .funct    (curFunct),
        .state    (state),
        .operation(operation)
    );

    alu u_alu (
        .operation(operation),
        .a        (operandA),
        .b        (operandB),
        .result   (aluResult)
    );

endmodule

//--- testbench/execUnit_chk.sv
`timescale 1ns/1ps

module execUnitChk #(
    parameter int cntW = 2
) (
    input logic                 clk,
    input logic                 arstN,
    input logic                 pop,
    input logic                 resValid,
    input rvExecPkg::seqState_e state,
    input logic [cntW-1:0]      creditCnt
);

    // number of failed assertions
    int assertFails = 0;

    // a result needs a free downstream slot
    resultNeedsCredit: assert property (@(posedge clk) disable iff (!arstN)
        resValid |-> (creditCnt != '0))
        else begin
            assertFails++;
            $error("resValid asserted with zero output credits");
        end

    // decode, execute, write after each pop
    popToResult: assert property (@(posedge clk) disable iff (!arstN)
        pop |-> ##3 resValid)
        else begin
            assertFails++;
            $error("resValid did not follow pop after 3 cycles");
        end

    // FSM never leaves the legal codes
    legalState: assert property (@(posedge clk) disable iff (!arstN)
        state inside {rvExecPkg::stIdle, rvExecPkg::stDecode, rvExecPkg::stExecR,
                      rvExecPkg::stExecI, rvExecPkg::stBranch, rvExecPkg::stWrite})
        else begin
            assertFails++;
            $error("sequencer state holds an illegal code");
        end

endmodule

bind execSequencer execUnitChk #(
    .cntW(cntW)
) u_chk (
    .clk      (clk),
    .arstN    (arstN),
    .pop      (pop),
    .resValid (resValid),
    .state    (state),
    .creditCnt(creditCnt)
);

//--- testbench/execUnitMonitor.sv
`timescale 1ns/1ps

module execUnitMonitor #(
    parameter int numInstr   = 64,
    parameter int resCredits = 2
) (
    input  logic               clk,
    input  logic               arstN,
    input  logic               instrValid,
    input  rvExecPkg::instr_t  instr,
    input  logic               instrCredit,
    input  logic               resValid,
    input  rvExecPkg::result_t res,
    input  logic               resCreditReturn,
    input  logic               endOfTest,
    output int                 resCount,
    output int                 errCount
);

    rvExecPkg::instr_t sentQ [$];
    int                sentCount;
    int                creditPulses;
    int                outstanding;

    function automatic rvExecPkg::xlen_t sext32(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    // expected value straight from the RV64I rules
    function automatic rvExecPkg::xlen_t expectedValue(input rvExecPkg::instr_t i);
        rvExecPkg::xlen_t   a;
        rvExecPkg::xlen_t   b;
        rvExecPkg::xlen_t   r;
        rvExecPkg::xlen_t   sraD;
        logic signed [63:0] sa;
        logic signed [31:0] sw;
        logic [31:0]        sraW;
        logic [2:0]         f3;
        logic               alt;
        logic               regForm;
        regForm = (i.opcode == rvExecPkg::opOp) || (i.opcode == rvExecPkg::opOp32);
        a       = i.rs1Val;
        // register forms and branches take rs2
        b       = (regForm || i.opcode == rvExecPkg::opBranch) ? i.rs2Val : i.imm;
        f3      = i.funct[2:0];
        alt     = i.funct[4];
        sa      = a;
        sw      = a[31:0];
        // arithmetic shifts kept apart from unsigned context
        sraD    = sa >>> b[5:0];
        sraW    = sw >>> b[4:0];
        case (i.opcode)
            rvExecPkg::opOp,
            rvExecPkg::opOpImm: begin
                case (f3)
                    3'b000:  r = (alt && regForm) ? a - b : a + b;
                    3'b001:  r = a << b[5:0];
                    3'b010:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                    3'b011:  r = (a < b) ? 64'd1 : 64'd0;
                    3'b100:  r = a ^ b;
                    3'b101:  r = alt ? sraD : a >> b[5:0];
                    3'b110:  r = a | b;
                    default: r = a & b;
                endcase
            end
            rvExecPkg::opOp32,
            rvExecPkg::opOpImm32: begin
                // low word only, then sign-extend
                case (f3)
                    3'b000:  r = sext32((alt && regForm) ? a[31:0] - b[31:0] : a[31:0] + b[31:0]);
                    3'b001:  r = sext32(a[31:0] << b[4:0]);
                    default: r = sext32(alt ? sraW : a[31:0] >> b[4:0]);
                endcase
            end
            // 1 when taken, bne is funct3 001
            rvExecPkg::opBranch: r = ((f3 == 3'b001) ? (a != b) : (a == b)) ? 64'd1 : 64'd0;
            default:             r = a + i.imm;
        endcase
        return r;
    endfunction

    initial begin
        resCount     = 0;
        errCount     = 0;
        sentCount    = 0;
        creditPulses = 0;
        outstanding  = 0;
    end

    always @(posedge clk) begin
        rvExecPkg::instr_t want;
        rvExecPkg::xlen_t  wantVal;
        logic              ok;
        if (arstN) begin
            if (instrValid) begin
                sentQ.push_back(instr);
                sentCount++;
            end
            if (instrCredit) begin
                creditPulses++;
            end
            if (resValid) begin
                // outstanding results must stay below the slot count
                if (outstanding >= resCredits) begin
                    errCount++;
                    $display("result sent at %0t while all %0d downstream slots were full",
                             $time, resCredits);
                end
                if (sentQ.size() == 0) begin
                    errCount++;
                    $display("result with tag %0d at %0t has no instruction in flight",
                             res.tag, $time);
                end else begin
                    want    = sentQ.pop_front();
                    wantVal = expectedValue(want);
                    ok      = 1'b1;
                    if (res.tag !== want.tag) begin
                        ok = 1'b0;
                        errCount++;
                        $display("mismatch at %0t: res.tag got %0d expected %0d",
                                 $time, res.tag, want.tag);
                    end
                    if (res.value !== wantVal) begin
                        ok = 1'b0;
                        errCount++;
                        $display("mismatch at %0t: res.value got %h expected %h",
                                 $time, res.value, wantVal);
                    end
                    resCount++;
                    $display("test %0d tag %0d opcode %b funct %b: %s", resCount, want.tag,
                             want.opcode, want.funct, ok ? "ok" : "failed");
                end
            end
            outstanding = outstanding + (resValid ? 1 : 0) - (resCreditReturn ? 1 : 0);
        end
    end

    // leftovers and credit totals once traffic has stopped
    always @(posedge endOfTest) begin
        if (sentQ.size() != 0) begin
            errCount++;
            $display("%0d results never arrived", sentQ.size());
        end
        if (sentCount != numInstr) begin
            errCount++;
            $display("%0d instructions entered the DUT, %0d were planned", sentCount, numInstr);
        end
        if (creditPulses != sentCount) begin
            errCount++;
            $display("instrCredit pulsed %0d times for %0d instructions",
                     creditPulses, sentCount);
        end
    end

endmodule

//--- testbench/execUnitTb.sv
`timescale 1ns/1ps

module execUnitTb;

    localparam int queueDepth   = 4;
    localparam int resCredits   = 2;
    localparam int numInstr     = 64;
    localparam int maxDelay     = 6;
    localparam int holdCycles   = 60;
    localparam int seedInit     = 65;
    // 4 cycles per instruction, slowed by the worst credit delay
    localparam int timeoutCycles = numInstr * 4 * maxDelay + holdCycles + 200;

    logic               clk;
    logic               arstN;
    logic               instrValid;
    rvExecPkg::instr_t  instr;
    logic               instrCredit;
    logic               resValid;
    rvExecPkg::result_t res;
    logic               resCreditReturn;
    logic               endOfTest;
    logic               holdCredits;
    logic [63:0]        seed = 64'(seedInit);
    rvExecPkg::instr_t  nextInstr;
    int                 resCount;
    int                 errCount;
    int                 sentCount = 0;
    int                 creditsBack = 0;
    int                 cycle = 0;
    int                 totalErrors;
    int                 dueQ [$];

    execUnit #(
        .queueDepth(queueDepth),
        .resCredits(resCredits)
    ) u_dut (
        .clk            (clk),
        .arstN          (arstN),
        .instrValid     (instrValid),
        .instr          (instr),
        .instrCredit    (instrCredit),
        .resValid       (resValid),
        .res            (res),
        .resCreditReturn(resCreditReturn)
    );

    execUnitMonitor #(
        .numInstr  (numInstr),
        .resCredits(resCredits)
    ) u_mon (
        .clk            (clk),
        .arstN          (arstN),
        .instrValid     (instrValid),
        .instr          (instr),
        .instrCredit    (instrCredit),
        .resValid       (resValid),
        .res            (res),
        .resCreditReturn(resCreditReturn),
        .endOfTest      (endOfTest),
        .resCount       (resCount),
        .errCount       (errCount)
    );

    function automatic logic [63:0] lcgNext(input logic [63:0] s);
        return s * 64'd6364136223846793005 + 64'd1442695040888963407;
    endfunction

    // upper half has the better bits
    function logic [31:0] draw();
        seed = lcgNext(seed);
        return seed[63:32];
    endfunction

    task automatic makeInstr(input int idx, output rvExecPkg::instr_t ins);
        logic [31:0] r;
        logic [31:0] r2;
        logic [2:0]  f3;
        logic        alt;
        r              = draw();
        r2             = draw();
        f3             = r[12:10];
        alt            = r[8];
        ins.tag        = idx[3:0];
        ins.rs1Val[63:32] = draw();
        ins.rs1Val[31:0]  = draw();
        ins.rs2Val[63:32] = draw();
        ins.rs2Val[31:0]  = draw();
        // 12-bit immediate, already sign-extended
        ins.imm        = {{52{r2[11]}}, r2[11:0]};
        // negative low word now and then
        if (r[16]) begin
            ins.rs1Val[31] = 1'b1;
        end
        case (r % 6)
            0: begin
                ins.opcode = rvExecPkg::opOp;
                ins.funct  = {alt && (f3 == 3'b000 || f3 == 3'b101), 1'b0, f3};
            end
            1: begin
                ins.opcode = rvExecPkg::opOpImm;
                ins.funct  = {alt && (f3 == 3'b101), 1'b0, f3};
            end
            2, 3: begin
                // word forms only have funct3 000, 001 and 101
                f3         = (r[11:10] == 2'd0) ? 3'b000 : (r[11:10] == 2'd1) ? 3'b001 : 3'b101;
                ins.opcode = (r % 6 == 2) ? rvExecPkg::opOp32 : rvExecPkg::opOpImm32;
                ins.funct  = {alt && (f3 == 3'b101 || (f3 == 3'b000 && r % 6 == 2)), 1'b0, f3};
            end
            4: begin
                ins.opcode = rvExecPkg::opBranch;
                ins.funct  = {4'b0000, r[10]};
                if (r[9]) begin
                    ins.rs2Val = ins.rs1Val;
                end
            end
            // LUI is outside the stage
            default: begin
                ins.opcode = 7'b0110111;
                ins.funct  = r[20:16];
            end
        endcase
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // credit bookkeeping and return times
    always @(posedge clk) begin
        cycle++;
        if (instrCredit) begin
            creditsBack++;
        end
        if (resValid) begin
            dueQ.push_back(cycle + 1 + int'(draw() % maxDelay));
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            #1;
            resCreditReturn = 1'b0;
            if (!holdCredits && dueQ.size() != 0 && dueQ[0] <= cycle) begin
                void'(dueQ.pop_front());
                resCreditReturn = 1'b1;
            end
        end
    end

    // withhold downstream credits for a stretch
    initial begin
        holdCredits = 1'b0;
        wait (sentCount >= numInstr / 3);
        @(posedge clk);
        holdCredits = 1'b1;
        repeat (holdCycles) @(posedge clk);
        holdCredits = 1'b0;
    end

    initial begin
        repeat (timeoutCycles) @(posedge clk);
        $display("timeout: %0d of %0d results arrived within %0d cycles",
                 resCount, numInstr, timeoutCycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        arstN           = 1'b0;
        instrValid      = 1'b0;
        instr           = '0;
        resCreditReturn = 1'b0;
        endOfTest       = 1'b0;
        repeat (4) @(posedge clk);
        #1 arstN = 1'b1;
        while (sentCount < numInstr) begin
            @(posedge clk);
            #1;
            // input credits start at queueDepth
            if (queueDepth + creditsBack - sentCount > 0) begin
                makeInstr(sentCount, nextInstr);
                instr      = nextInstr;
                instrValid = 1'b1;
                sentCount++;
            end else begin
                instrValid = 1'b0;
            end
        end
        @(posedge clk);
        #1 instrValid = 1'b0;
        while (resCount < numInstr) begin
            @(posedge clk);
        end
        // room for a repeated result to show up
        repeat (20) @(posedge clk);
        endOfTest = 1'b1;
        #1;
        totalErrors = errCount + u_dut.u_seq.u_chk.assertFails;
        $display("summary: %0d of %0d results checked, %0d errors",
                 resCount, numInstr, totalErrors);
        if (totalErrors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- execUnit.f
logic/rvExecPkg.sv
logic/instrQueue.sv
logic/aluControl.sv
logic/alu.sv
logic/execSequencer.sv
logic/execUnit.sv
testbench/execUnit_chk.sv
testbench/execUnitMonitor.sv
testbench/execUnitTb.sv
